// File: common/draw_pkg.sv
// drawing subsystem shared definitions
// coordinate and colour widths, command opcodes, rasterizer states

package draw_pkg;

    // datapath widths
    localparam int CORDW = 16;  // signed coordinate width
    localparam int CIDXW = 4;   // colour index width

    // host command opcode
    typedef enum logic {
        op_line  = 1'b0,  // bresenham line x0,y0 to x1,y1
        op_clear = 1'b1   // fill whole bitmap with one colour
    } draw_op_e;

    // rasterizer FSM
    // st_line and st_clear both hold until the queue has drained,
    // so the host sees busy until every pixel is in memory
    typedef enum logic [1:0] {
        st_idle  = 2'd0,  // waiting for a command
        st_line  = 2'd1,  // stepping along a line
        st_clear = 2'd2   // row-major sweep of the bitmap
    } raster_state_e;

endpackage

// File: draw_raster/bitmap_addr.sv
// pixel address stage: signed coordinate to linear framebuffer address
// three registered stages, bounds clip flag travels with the pixel

`timescale 1ns/1ps

module bitmap_addr import draw_pkg::*; #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 24,
    parameter int ADDRW     = 10
) (
    input  logic                    clk_sys,
    input  logic                    rst_sys,
    input  logic                    pix_valid,
    input  logic signed [CORDW-1:0] pix_x,
    input  logic signed [CORDW-1:0] pix_y,
    input  logic [CIDXW-1:0]        pix_cidx,
    output logic                    wr_valid,
    output logic [ADDRW-1:0]        wr_addr,
    output logic                    wr_clip,   // outside bitmap, address meaningless
    output logic [CIDXW-1:0]        wr_cidx
);

    // stage 1: registered inputs and bounds check
    logic signed [CORDW-1:0] s1_x, s1_y;
    logic                    s1_valid, s1_clip;
    logic [CIDXW-1:0]        s1_cidx;
    // stage 2: row base
    logic [ADDRW-1:0]        s2_row, s2_x;
    logic                    s2_valid, s2_clip;
    logic [CIDXW-1:0]        s2_cidx;

    always_ff @(posedge clk_sys) begin
        s1_x    <= pix_x;
        s1_y    <= pix_y;
        s1_cidx <= pix_cidx;
        s1_clip <= (pix_x < 0) || (pix_x >= CORDW'(FB_WIDTH))
                || (pix_y < 0) || (pix_y >= CORDW'(FB_HEIGHT));

        s2_row  <= ADDRW'(s1_y * FB_WIDTH);  // y times width
        s2_x    <= ADDRW'(s1_x);
        s2_cidx <= s1_cidx;
        s2_clip <= s1_clip;

        wr_addr <= s2_row + s2_x;  // stage 3
        wr_cidx <= s2_cidx;
        wr_clip <= s2_clip;
    end

    // valid shift, only control bits see reset
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            s1_valid <= pix_valid;
            s2_valid <= s1_valid;
            wr_valid <= s2_valid;
        end
    end

endmodule

// File: draw_raster/draw_rasterizer.sv
// rasterizer: takes host commands and emits one pixel per cycle
// bresenham stepping for lines, row-major sweep for clear, credit gated

`timescale 1ns/1ps

module draw_rasterizer import draw_pkg::*; #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 24,
    parameter int WQ_DEPTH  = 4
) (
    input  logic                    clk_sys,
    input  logic                    rst_sys,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  draw_op_e                cmd_op,
    input  logic signed [CORDW-1:0] cmd_x0,
    input  logic signed [CORDW-1:0] cmd_y0,
    input  logic signed [CORDW-1:0] cmd_x1,
    input  logic signed [CORDW-1:0] cmd_y1,
    input  logic [CIDXW-1:0]        cmd_cidx,
    input  logic                    credit_ret,  // one per retired queue entry
    output logic                    pix_valid,
    output logic signed [CORDW-1:0] pix_x,
    output logic signed [CORDW-1:0] pix_y,
    output logic [CIDXW-1:0]        pix_cidx,
    output logic                    busy
);

    localparam int EW  = CORDW + 4;           // error term, room for 2*err
    localparam int CRW = $clog2(WQ_DEPTH + 1);

    raster_state_e           state;
    logic [CRW-1:0]          credits;
    logic                    drain;           // last pixel sent, waiting on credits
    logic signed [CORDW-1:0] x, y;            // current position
    logic signed [CORDW-1:0] x_end, y_end;    // line end point
    logic signed [EW-1:0]    dx, dy, err;     // dy held negative
    logic                    sx_neg, sy_neg;  // step direction
    logic [CIDXW-1:0]        cidx;

    logic signed [EW-1:0]    span_x, span_y, adx, ady, e2;
    logic                    move_x, move_y, last_pix, take;

    assign take      = cmd_valid && cmd_ready;
    assign cmd_ready = (state == st_idle);
    assign busy      = (state != st_idle);
    assign pix_valid = (state != st_idle) && !drain && (credits != '0);
    assign pix_x     = x;
    assign pix_y     = y;
    assign pix_cidx  = cidx;

    always_comb begin
        span_x = EW'(cmd_x1) - EW'(cmd_x0);  // sign-extended difference
        span_y = EW'(cmd_y1) - EW'(cmd_y0);
        adx    = (span_x < 0) ? -span_x : span_x;
        ady    = (span_y < 0) ? -span_y : span_y;
        e2     = err <<< 1;
        move_x = (e2 >= dy);
        move_y = (e2 <= dx);
        if (state == st_line)
            last_pix = (x == x_end) && (y == y_end);
        else  // clear ends on bottom right corner
            last_pix = (x == CORDW'(FB_WIDTH - 1)) && (y == CORDW'(FB_HEIGHT - 1));
    end

    // control
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state   <= st_idle;
            credits <= CRW'(WQ_DEPTH);
            drain   <= 1'b0;
        end else begin
            credits <= credits + CRW'(credit_ret) - CRW'(pix_valid);
            case (state)
                st_idle: begin
                    if (take) begin
                        state <= (cmd_op == op_line) ? st_line : st_clear;
                        drain <= 1'b0;
                    end
                end
                st_line, st_clear: begin
                    if (pix_valid && last_pix) drain <= 1'b1;
                    if (drain && credits == CRW'(WQ_DEPTH)) state <= st_idle;  // all retired
                end
                default: state <= st_idle;
            endcase
        end
    end

    // position and bresenham terms
    always_ff @(posedge clk_sys) begin
        if (take) begin
            cidx   <= cmd_cidx;
            x_end  <= cmd_x1;
            y_end  <= cmd_y1;
            dx     <= adx;
            dy     <= -ady;
            err    <= adx - ady;
            sx_neg <= (span_x < 0);
            sy_neg <= (span_y < 0);
            if (cmd_op == op_line) begin
                x <= cmd_x0;
                y <= cmd_y0;
            end else begin  // sweep starts top left
                x <= '0;
                y <= '0;
            end
        end else if (pix_valid && !last_pix) begin
            if (state == st_line) begin
                err <= err + (move_x ? dy : EW'(0)) + (move_y ? dx : EW'(0));
                if (move_x) x <= sx_neg ? x - 2'sd1 : x + 2'sd1;
                if (move_y) y <= sy_neg ? y - 2'sd1 : y + 2'sd1;
            end else if (x == CORDW'(FB_WIDTH - 1)) begin
                x <= '0;  // next row
                y <= y + 2'sd1;
            end else begin
                x <= x + 2'sd1;
            end
        end
    end

    // returned credits never push the count above the queue depth
    a_credit_max: assert property (@(posedge clk_sys) disable iff (rst_sys)
        credits <= CRW'(WQ_DEPTH));

    // spending the last credit with none coming back stalls the next cycle
    a_pix_credit: assert property (@(posedge clk_sys) disable iff (rst_sys)
        pix_valid && credits == CRW'(1) && !credit_ret |=> !pix_valid);

endmodule

// File: framebuffer/framebuffer.sv
// framebuffer: small write queue in front of the pixel memory
// host reads win over queue pops, each retired entry returns a credit

`timescale 1ns/1ps

module framebuffer import draw_pkg::*; #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 24,
    parameter int ADDRW     = 10,
    parameter int WQ_DEPTH  = 4
) (
    input  logic             clk_sys,
    input  logic             rst_sys,
    input  logic             wr_valid,
    input  logic [ADDRW-1:0] wr_addr,
    input  logic             wr_clip,
    input  logic [CIDXW-1:0] wr_cidx,
    input  logic             rd_en,
    input  logic [ADDRW-1:0] rd_addr,
    output logic [CIDXW-1:0] rd_data,     // one cycle after rd_en
    output logic             credit_ret
);

    localparam int PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int PTRW   = (WQ_DEPTH > 1) ? $clog2(WQ_DEPTH) : 1;
    localparam int CNTW   = $clog2(WQ_DEPTH + 1);

    logic [ADDRW-1:0] q_addr [WQ_DEPTH];
    logic             q_clip [WQ_DEPTH];
    logic [CIDXW-1:0] q_cidx [WQ_DEPTH];
    logic [PTRW-1:0]  wr_ptr, rd_ptr;
    logic [CNTW-1:0]  q_count;
    logic             pop;
    logic [CIDXW-1:0] mem [PIXELS];

    function automatic logic [PTRW-1:0] ptr_inc(input logic [PTRW-1:0] p);
        return (p == PTRW'(WQ_DEPTH - 1)) ? '0 : p + 1'b1;  // wrap at depth
    endfunction

    assign pop = (q_count != '0) && !rd_en;  // read port has priority

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_count    <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (wr_valid) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            q_count    <= q_count + CNTW'(wr_valid) - CNTW'(pop);
            credit_ret <= pop;  // clipped entries return credit too
        end
    end

    // queue storage
    always_ff @(posedge clk_sys) begin
        if (wr_valid) begin
            q_addr[wr_ptr] <= wr_addr;
            q_clip[wr_ptr] <= wr_clip;
            q_cidx[wr_ptr] <= wr_cidx;
        end
    end

    // pixel memory, one write and one read port
    always_ff @(posedge clk_sys) begin
        if (pop && !q_clip[rd_ptr]) mem[q_addr[rd_ptr]] <= q_cidx[rd_ptr];
        if (rd_en) rd_data <= mem[rd_addr];
    end

    // rasterizer credits must keep the queue from overflowing
    a_no_overflow: assert property (@(posedge clk_sys) disable iff (rst_sys)
        wr_valid |-> q_count != CNTW'(WQ_DEPTH));

endmodule

// File: list.f
common/draw_pkg.sv
draw_raster/draw_rasterizer.sv
draw_raster/bitmap_addr.sv
framebuffer/framebuffer.sv
logic/draw_top.sv
sim/tb_draw.sv

// File: logic/draw_top.sv
// drawing subsystem top level
// rasterizer, address pipeline and framebuffer on one clock

`timescale 1ns/1ps

module draw_top import draw_pkg::*; #(
    parameter int   FB_WIDTH  = 32,
    parameter int   FB_HEIGHT = 24,
    parameter int   WQ_DEPTH  = 4,
    localparam int  ADDRW     = $clog2(FB_WIDTH * FB_HEIGHT)
) (
    input  logic                    clk_sys,
    input  logic                    rst_sys,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  draw_op_e                cmd_op,
    input  logic signed [CORDW-1:0] cmd_x0,
    input  logic signed [CORDW-1:0] cmd_y0,
    input  logic signed [CORDW-1:0] cmd_x1,
    input  logic signed [CORDW-1:0] cmd_y1,
    input  logic [CIDXW-1:0]        cmd_cidx,
    input  logic                    rd_en,
    input  logic [ADDRW-1:0]        rd_addr,
    output logic [CIDXW-1:0]        rd_data,
    output logic                    busy
);

    logic                    pix_valid, wr_valid, wr_clip, credit_ret;
    logic signed [CORDW-1:0] pix_x, pix_y;
    logic [CIDXW-1:0]        pix_cidx, wr_cidx;
    logic [ADDRW-1:0]        wr_addr;

    draw_rasterizer #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .WQ_DEPTH(WQ_DEPTH)
    ) u_raster (
        .clk_sys, .rst_sys, .cmd_valid, .cmd_ready, .cmd_op,
        .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1, .cmd_cidx, .credit_ret,
        .pix_valid, .pix_x, .pix_y, .pix_cidx, .busy
    );

    bitmap_addr #(  // fixed 3 cycle latency
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .ADDRW(ADDRW)
    ) u_addr (
        .clk_sys, .rst_sys, .pix_valid, .pix_x, .pix_y, .pix_cidx,
        .wr_valid, .wr_addr, .wr_clip, .wr_cidx
    );

    framebuffer #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .ADDRW(ADDRW), .WQ_DEPTH(WQ_DEPTH)
    ) u_fb (
        .clk_sys, .rst_sys, .wr_valid, .wr_addr, .wr_clip, .wr_cidx,
        .rd_en, .rd_addr, .rd_data, .credit_ret
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the drawing subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_draw -o sim_draw

# the log decides, not the exit status of the pipe
./obj_dir/sim_draw | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL"
    exit 1
fi

// File: sim/tb_draw.sv
// testbench for the drawing subsystem
// directed and random commands against a bitmap model, full readback after each

`timescale 1ns/1ps

module tb_draw import draw_pkg::*; ();

    localparam int FB_WIDTH  = 32;
    localparam int FB_HEIGHT = 24;
    localparam int WQ_DEPTH  = 4;
    localparam int PIXELS    = FB_WIDTH * FB_HEIGHT;
    localparam int ADDRW     = $clog2(PIXELS);
    localparam int TIMEOUT   = 20000;  // cycles per wait

    logic                    clk_sys = 1'b0;
    logic                    rst_sys;
    logic                    cmd_valid, cmd_ready, busy, rd_en;
    draw_op_e                cmd_op;
    logic signed [CORDW-1:0] cmd_x0, cmd_y0, cmd_x1, cmd_y1;
    logic [CIDXW-1:0]        cmd_cidx, rd_data;
    logic [ADDRW-1:0]        rd_addr;

    logic [CIDXW-1:0]        model [PIXELS];  // shadow bitmap

    draw_top #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .WQ_DEPTH(WQ_DEPTH)) uut (
        .clk_sys, .rst_sys, .cmd_valid, .cmd_ready, .cmd_op,
        .cmd_x0, .cmd_y0, .cmd_x1, .cmd_y1, .cmd_cidx,
        .rd_en, .rd_addr, .rd_data, .busy
    );

    always #10 clk_sys = ~clk_sys;  // 20 ns period

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // reset and command handshake
    a_reset_state: assert property (@(posedge clk_sys) rst_sys |=> cmd_ready && !busy)
        else abort_run($sformatf("Error: %0t ns: cmd_ready/busy wrong in reset", $time));
    a_ready_busy: assert property (@(posedge clk_sys) disable iff (rst_sys) busy |-> !cmd_ready)
        else abort_run($sformatf("Error: %0t ns: cmd_ready high while busy", $time));
    a_take_busy: assert property (@(posedge clk_sys) disable iff (rst_sys)
        cmd_valid && cmd_ready |=> busy)
        else abort_run($sformatf("Error: %0t ns: accepted command did not raise busy", $time));

    function automatic void model_plot(int px, int py, logic [CIDXW-1:0] c);
        if (px >= 0 && px < FB_WIDTH && py >= 0 && py < FB_HEIGHT)  // clip, no wrap
            model[py * FB_WIDTH + px] = c;
    endfunction

    function automatic void model_clear(logic [CIDXW-1:0] c);
        for (int a = 0; a < PIXELS; a++)
            model[a] = c;
    endfunction

    // bresenham walk, both endpoints included
    function automatic void model_line(int x0, int y0, int x1, int y1, logic [CIDXW-1:0] c);
        int dx, dy, sx, sy, err, e2, x, y;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // kept negative
        sx  = (x0 < x1) ? 1 : -1;
        sy  = (y0 < y1) ? 1 : -1;
        err = dx + dy;
        x   = x0;
        y   = y0;
        model_plot(x, y, c);
        while (x != x1 || y != y1) begin
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
            model_plot(x, y, c);
        end
    endfunction

    task automatic step();
        @(posedge clk_sys);
        #1;  // drive just after the edge
    endtask

    task automatic issue_cmd(draw_op_e op, int x0, int y0, int x1, int y1,
                             logic [CIDXW-1:0] c);
        int n;
        n = 0;
        while (!cmd_ready) begin
            n++;
            if (n > TIMEOUT) abort_run("timeout: cmd_ready never came back high");
            step();
        end
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_x0    = CORDW'(x0);
        cmd_y0    = CORDW'(y0);
        cmd_x1    = CORDW'(x1);
        cmd_y1    = CORDW'(y1);
        cmd_cidx  = c;
        step();  // taken on this edge
        cmd_valid = 1'b0;
        if (op == op_clear)
            model_clear(c);
        else
            model_line(x0, y0, x1, y1, c);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            n++;
            if (n > TIMEOUT) abort_run("timeout: busy stayed high, command never finished");
            step();
        end
    endtask

    // one address per cycle, data checked one cycle after rd_en
    task automatic check_image();
        for (int a = 0; a < PIXELS; a++) begin
            rd_en   = 1'b1;
            rd_addr = ADDRW'(a);
            step();
            a_readback: assert (rd_data == model[a])
                else abort_run($sformatf("Error: %0t ns: addr %0d reads %0d, expected %0d",
                                         $time, a, rd_data, model[a]));
        end
        rd_en = 1'b0;
    endtask

    task automatic draw_and_check(int x0, int y0, int x1, int y1, logic [CIDXW-1:0] c);
        issue_cmd(op_line, x0, y0, x1, y1, c);
        wait_idle();
        check_image();
    endtask

    function automatic int rand_coord(int span);
        return int'($urandom % 32'(span + 16)) - 8;  // 8 beyond each edge
    endfunction

    initial begin
        rst_sys   = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = op_line;
        cmd_x0    = '0;
        cmd_y0    = '0;
        cmd_x1    = '0;
        cmd_y1    = '0;
        cmd_cidx  = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        void'($urandom(5150));
        repeat (5) @(posedge clk_sys);
        #1;
        rst_sys = 1'b0;

        a_after_reset: assert (cmd_ready && !busy)
            else abort_run($sformatf("Error: %0t ns: not idle after reset", $time));

        issue_cmd(op_clear, 0, 0, 0, 0, 4'd5);  // whole bitmap to 5
        wait_idle();
        check_image();

        draw_and_check(2, 3, 20, 3, 4'd1);     // horizontal
        draw_and_check(5, 1, 5, 22, 4'd2);     // vertical
        draw_and_check(0, 0, 23, 23, 4'd3);    // diagonal
        draw_and_check(10, 10, 10, 10, 4'd4);  // single point
        draw_and_check(28, 20, 3, 4, 4'd6);    // reverse, shallow
        draw_and_check(30, 2, 25, 22, 4'd7);   // reverse, steep

        // endpoints partly off the bitmap
        for (int i = 0; i < 12; i++)
            draw_and_check(rand_coord(FB_WIDTH), rand_coord(FB_HEIGHT),
                           rand_coord(FB_WIDTH), rand_coord(FB_HEIGHT),
                           CIDXW'($urandom));

        // reads stall the queue, credits run dry
        issue_cmd(op_line, 0, 0, 31, 23, 4'd9);
        for (int i = 0; i < 60; i++) begin
            rd_en   = 1'b1;
            rd_addr = ADDRW'($urandom % PIXELS);
            step();
            a_busy_hold: assert (busy)
                else abort_run($sformatf("Error: %0t ns: busy fell during reads", $time));
        end
        rd_en = 1'b0;
        wait_idle();
        check_image();

        // a command offered while busy must be ignored
        issue_cmd(op_clear, 0, 0, 0, 0, 4'd2);
        cmd_valid = 1'b1;
        cmd_op    = op_line;
        cmd_x0    = '0;
        cmd_y0    = '0;
        cmd_x1    = CORDW'(FB_WIDTH - 1);
        cmd_y1    = '0;
        cmd_cidx  = 4'd15;
        repeat (10) step();
        cmd_valid = 1'b0;  // dropped before clear ends
        wait_idle();
        check_image();

        // crossing lines, later colour wins at (16,12)
        draw_and_check(0, 12, 31, 12, 4'd3);
        draw_and_check(16, 0, 16, 23, 4'd12);

        $display("Verification passed");
        $finish;
    end

endmodule
